/* verilog/isa_pkg.sv */
// isa_pkg
// RISC-V integer ALU subset: word types, R/I field layouts,
// opcode and funct codes, and the internal ALU operation encoding
package isa_pkg;

	// data path width and register count
	localparam int xlen     = 32;
	localparam int num_regs = 32;

	typedef logic [xlen-1:0] word_t;
	typedef logic [4:0]      reg_idx_t;

	// register-register layout
	typedef struct packed {
		logic [6:0] funct7;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		reg_idx_t   rd;
		logic [6:0] opcode;
	} r_type_t;

	// register-immediate layout, imm sits where funct7/rs2 are
	typedef struct packed {
		logic [11:0] imm;
		reg_idx_t    rs1;
		logic [2:0]  funct3;
		reg_idx_t    rd;
		logic [6:0]  opcode;
	} i_type_t;

	// one instruction word, viewed by opcode as either form
	typedef union packed {
		r_type_t r;
		i_type_t i;
	} inst_u;

	// major opcodes
	localparam logic [6:0] op_reg = 7'b0110011;
	localparam logic [6:0] op_imm = 7'b0010011;

	// funct3, shared by both forms
	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_xor     = 3'b100;
	localparam logic [2:0] f3_or      = 3'b110;
	localparam logic [2:0] f3_and     = 3'b111;

	// funct7, register form only
	localparam logic [6:0] f7_base = 7'b0000000;
	localparam logic [6:0] f7_sub  = 7'b0100000;

	typedef enum logic [3:0] {
		alu_add = 4'd0,
		alu_sub = 4'd1,
		alu_and = 4'd2,
		alu_or  = 4'd3,
		alu_xor = 4'd4
	} alu_op_e;

endpackage

/* verilog/core_pkg.sv */
// core_pkg
// sizes of the out-of-order core and the renamed operand format
// shared by issue, the reservation stations and the dispatch bundle
package core_pkg;

	// reservation-station entries, also the tag space
	localparam int num_entries = 4;
	localparam int tag_bits    = $clog2(num_entries);

	// tag = entry number, since there is no ROB
	typedef logic [tag_bits-1:0] tag_t;

	// one source operand after renaming
	//   pending = 1 : value is not yet known, wait for tag on the CDB
	//   pending = 0 : value holds the operand
	typedef struct packed {
		logic          pending;
		tag_t          tag;
		isa_pkg::word_t value;
	} operand_t;

endpackage

/* verilog/rs_dispatch_if.sv */
// rs_dispatch_if
// one renamed instruction from the issue unit to the entry array;
// only the entry named by target loads it
`timescale 1ns/10ps

interface rs_dispatch_if;

	logic               valid;
	core_pkg::tag_t     target;
	isa_pkg::alu_op_e   alu_op;
	core_pkg::operand_t src1;
	core_pkg::operand_t src2;

	// issue side
	modport source (
		output valid, target, alu_op, src1, src2
	);

	// entry side
	modport sink (
		input valid, target, alu_op, src1, src2
	);

endinterface

/* verilog/issue_unit.sv */
// issue_unit
// decodes one instruction per cycle, renames its sources through the
// map table, picks the lowest free entry and dispatches into it;
// also owns the register file and retires CDB results into it
`timescale 1ns/10ps

module issue_unit (
	input  logic                               clock,
	input  logic                               reset,
	input  logic                               issue_valid,
	input  isa_pkg::inst_u                     issue_inst,
	output logic                               issue_stall,
	input  logic [core_pkg::num_entries-1:0]   busy,
	input  logic                               cdb_valid,
	input  core_pkg::tag_t                     cdb_tag,
	input  isa_pkg::word_t                     cdb_value,
	input  isa_pkg::reg_idx_t                  read_idx,
	output isa_pkg::word_t                     read_data,
	output logic                               wb_valid,
	output isa_pkg::reg_idx_t                  wb_rd,
	output isa_pkg::word_t                     wb_data,
	rs_dispatch_if.source                      dsp
);

	// architectural state
	isa_pkg::word_t regs [isa_pkg::num_regs];
	core_pkg::tag_t map_tag [isa_pkg::num_regs];
	logic [isa_pkg::num_regs-1:0] map_pending;

	isa_pkg::alu_op_e dec_op;
	logic dec_ok;
	logic use_imm;
	isa_pkg::word_t imm_ext;
	core_pkg::operand_t rd1;
	core_pkg::operand_t rd2;
	core_pkg::tag_t free_idx;
	logic fire;
	logic wb_hit;
	isa_pkg::reg_idx_t wb_idx;

	// source read with same-cycle CDB bypass
	function automatic core_pkg::operand_t read_operand(
		logic pend, core_pkg::tag_t tag, isa_pkg::word_t value,
		logic bus_valid, core_pkg::tag_t bus_tag, isa_pkg::word_t bus_value);
		core_pkg::operand_t op;
		op.pending = pend;
		op.tag     = tag;
		op.value   = value;
		if (pend && bus_valid && bus_tag == tag) begin
			op.pending = 1'b0;
			op.value   = bus_value;
		end
		return op;
	endfunction

	////////////////////////////////////////
	// decode
	////////////////////////////////////////

	always_comb begin
		dec_ok  = 1'b0;
		dec_op  = isa_pkg::alu_add;
		use_imm = 1'b0;
		case (issue_inst.r.opcode)
			isa_pkg::op_reg: begin
				// funct7 is the base code except for SUB
				case (issue_inst.r.funct3)
					isa_pkg::f3_add_sub: begin
						dec_ok = issue_inst.r.funct7 == isa_pkg::f7_base ||
							issue_inst.r.funct7 == isa_pkg::f7_sub;
						dec_op = (issue_inst.r.funct7 == isa_pkg::f7_sub) ?
							isa_pkg::alu_sub : isa_pkg::alu_add;
					end
					isa_pkg::f3_xor: begin
						dec_ok = issue_inst.r.funct7 == isa_pkg::f7_base;
						dec_op = isa_pkg::alu_xor;
					end
					isa_pkg::f3_or: begin
						dec_ok = issue_inst.r.funct7 == isa_pkg::f7_base;
						dec_op = isa_pkg::alu_or;
					end
					isa_pkg::f3_and: begin
						dec_ok = issue_inst.r.funct7 == isa_pkg::f7_base;
						dec_op = isa_pkg::alu_and;
					end
					default: dec_ok = 1'b0;
				endcase
			end
			isa_pkg::op_imm: begin
				use_imm = 1'b1;
				// funct3 000 is ADDI since there is no SUBI
				case (issue_inst.i.funct3)
					isa_pkg::f3_add_sub: begin
						dec_ok = 1'b1;
						dec_op = isa_pkg::alu_add;
					end
					isa_pkg::f3_xor: begin
						dec_ok = 1'b1;
						dec_op = isa_pkg::alu_xor;
					end
					isa_pkg::f3_or: begin
						dec_ok = 1'b1;
						dec_op = isa_pkg::alu_or;
					end
					isa_pkg::f3_and: begin
						dec_ok = 1'b1;
						dec_op = isa_pkg::alu_and;
					end
					default: dec_ok = 1'b0;
				endcase
			end
			default: dec_ok = 1'b0;
		endcase
	end

	assign imm_ext = {{(isa_pkg::xlen-12){issue_inst.i.imm[11]}}, issue_inst.i.imm};

	// rename both sources
	assign rd1 = read_operand(map_pending[issue_inst.r.rs1], map_tag[issue_inst.r.rs1],
		regs[issue_inst.r.rs1], cdb_valid, cdb_tag, cdb_value);
	assign rd2 = read_operand(map_pending[issue_inst.r.rs2], map_tag[issue_inst.r.rs2],
		regs[issue_inst.r.rs2], cdb_valid, cdb_tag, cdb_value);

	////////////////////////////////////////
	// entry choice and dispatch
	////////////////////////////////////////

	// lowest free entry wins with a top-down scan
	always_comb begin
		free_idx = '0;
		for (int i = core_pkg::num_entries - 1; i >= 0; i--) begin
			if (!busy[i])
				free_idx = core_pkg::tag_t'(i);
		end
	end

	assign issue_stall = &busy;
	// unknown words are taken and dropped
	assign fire = issue_valid && !issue_stall && dec_ok;

	assign dsp.valid  = fire;
	assign dsp.target = free_idx;
	assign dsp.alu_op = dec_op;
	assign dsp.src1   = rd1;
	assign dsp.src2   = use_imm ?
		core_pkg::operand_t'{pending: 1'b0, tag: '0, value: imm_ext} : rd2;

	////////////////////////////////////////
	// result retire and map update
	////////////////////////////////////////

	// at most one register can still name the broadcast tag
	always_comb begin
		wb_hit = 1'b0;
		wb_idx = '0;
		for (int r = 1; r < isa_pkg::num_regs; r++) begin
			if (cdb_valid && map_pending[r] && map_tag[r] == cdb_tag) begin
				wb_hit = 1'b1;
				wb_idx = isa_pkg::reg_idx_t'(r);
			end
		end
	end

	assign wb_valid = wb_hit;
	assign wb_rd    = wb_idx;
	assign wb_data  = cdb_value;

	always_ff @(posedge clock) begin
		if (reset) begin
			map_pending <= '0;
			for (int r = 0; r < isa_pkg::num_regs; r++) begin
				regs[r]    <= '0;
				map_tag[r] <= '0;
			end
		end else begin
			if (wb_hit) begin
				regs[wb_idx]        <= cdb_value;
				map_pending[wb_idx] <= 1'b0;
			end
			// later assignment lets a new rename beat a retiring result
			if (fire && issue_inst.r.rd != '0) begin
				map_pending[issue_inst.r.rd] <= 1'b1;
				map_tag[issue_inst.r.rd]     <= free_idx;
			end
		end
	end

	// x0 is never written and stays zero
	assign read_data = regs[read_idx];

	// dispatch target must be a free entry
	assert property (@(posedge clock) disable iff (reset) dsp.valid |-> !busy[dsp.target])
		else $error("dispatch to busy entry %0d", dsp.target);

	// x0 never renamed
	assert property (@(posedge clock) disable iff (reset) !map_pending[0])
		else $error("x0 holds a tag");

endmodule

/* verilog/rs_entry.sv */
// rs_entry
// one reservation-station entry: holds a dispatched instruction,
// snoops the CDB for its pending operands and frees on grant
`timescale 1ns/10ps

module rs_entry (
	input  logic             clock,
	input  logic             reset,
	input  core_pkg::tag_t   index,
	rs_dispatch_if.sink      dsp,
	input  logic             cdb_valid,
	input  core_pkg::tag_t   cdb_tag,
	input  isa_pkg::word_t   cdb_value,
	input  logic             grant,
	output logic             busy,
	output logic             ready,
	output isa_pkg::alu_op_e alu_op,
	output isa_pkg::word_t   value1,
	output isa_pkg::word_t   value2
);

	logic busy_q;
	isa_pkg::alu_op_e op_q;
	core_pkg::operand_t src1_q;
	core_pkg::operand_t src2_q;
	logic load;

	// capture a result for a waiting operand
	function automatic core_pkg::operand_t snoop(core_pkg::operand_t op,
		logic bus_valid, core_pkg::tag_t bus_tag, isa_pkg::word_t bus_value);
		core_pkg::operand_t res;
		res = op;
		if (op.pending && bus_valid && op.tag == bus_tag) begin
			res.pending = 1'b0;
			res.value   = bus_value;
		end
		return res;
	endfunction

	assign load = dsp.valid && dsp.target == index;

	// control bit
	always_ff @(posedge clock) begin
		if (reset)
			busy_q <= 1'b0;
		else if (load)
			busy_q <= 1'b1;
		else if (grant)
			busy_q <= 1'b0;
	end

	// payload, bus match seen at its own edge
	always_ff @(posedge clock) begin
		if (load) begin
			op_q   <= dsp.alu_op;
			src1_q <= dsp.src1;
			src2_q <= dsp.src2;
		end else if (busy_q) begin
			src1_q <= snoop(src1_q, cdb_valid, cdb_tag, cdb_value);
			src2_q <= snoop(src2_q, cdb_valid, cdb_tag, cdb_value);
		end
	end

	assign busy   = busy_q;
	assign ready  = busy_q && !src1_q.pending && !src2_q.pending;
	assign alu_op = op_q;
	assign value1 = src1_q.value;
	assign value2 = src2_q.value;

	// issue must only target a free entry
	assert property (@(posedge clock) disable iff (reset) load |-> !busy_q)
		else $error("dispatch into busy entry %0d", index);

	// selector must respect readiness
	assert property (@(posedge clock) disable iff (reset) grant |-> ready)
		else $error("grant to entry %0d while not ready", index);

endmodule

/* verilog/alu_writeback.sv */
// alu_writeback
// picks the lowest ready entry, runs it through the single ALU and
// registers the tag and result onto the common data bus
`timescale 1ns/10ps

module alu_writeback (
	input  logic                             clock,
	input  logic                             reset,
	input  logic [core_pkg::num_entries-1:0] ready,
	input  isa_pkg::alu_op_e                 alu_op [core_pkg::num_entries],
	input  isa_pkg::word_t                   value1 [core_pkg::num_entries],
	input  isa_pkg::word_t                   value2 [core_pkg::num_entries],
	output logic [core_pkg::num_entries-1:0] grant,
	output logic                             cdb_valid,
	output core_pkg::tag_t                   cdb_tag,
	output isa_pkg::word_t                   cdb_value
);

	core_pkg::tag_t sel;
	logic any_ready;
	isa_pkg::word_t op_a;
	isa_pkg::word_t op_b;
	isa_pkg::word_t result;

	// fixed priority with lowest index first
	always_comb begin
		sel       = '0;
		any_ready = 1'b0;
		for (int i = core_pkg::num_entries - 1; i >= 0; i--) begin
			if (ready[i]) begin
				sel       = core_pkg::tag_t'(i);
				any_ready = 1'b1;
			end
		end
	end

	// one-hot of sel or empty when nothing is ready
	always_comb begin
		grant = '0;
		if (any_ready)
			grant[sel] = 1'b1;
	end

	assign op_a = value1[sel];
	assign op_b = value2[sel];

	// single-cycle ALU
	always_comb begin
		case (alu_op[sel])
			isa_pkg::alu_add: result = op_a + op_b;
			isa_pkg::alu_sub: result = op_a - op_b;
			isa_pkg::alu_and: result = op_a & op_b;
			isa_pkg::alu_or:  result = op_a | op_b;
			isa_pkg::alu_xor: result = op_a ^ op_b;
			default:          result = '0;
		endcase
	end

	// bus strobe
	always_ff @(posedge clock) begin
		if (reset)
			cdb_valid <= 1'b0;
		else
			cdb_valid <= any_ready;
	end

	// bus payload qualified by cdb_valid
	always_ff @(posedge clock) begin
		cdb_tag   <= sel;
		cdb_value <= result;
	end

	// grant is one-hot or zero and names the lowest ready entry
	assert property (@(posedge clock) disable iff (reset)
		$onehot0(grant) && grant == (ready & -ready))
		else $error("grant not the lowest ready entry");

endmodule

/* verilog/tomasulo_core.sv */
// tomasulo_core
// top of the out-of-order ALU core: issue unit, the array of
// reservation-station entries and the ALU that drives the CDB
`timescale 1ns/10ps

module tomasulo_core (
	input  logic              clock,
	input  logic              reset,
	input  logic              issue_valid,
	input  logic [31:0]       issue_inst,
	output logic              issue_stall,
	input  isa_pkg::reg_idx_t read_idx,
	output isa_pkg::word_t    read_data,
	output logic              wb_valid,
	output isa_pkg::reg_idx_t wb_rd,
	output isa_pkg::word_t    wb_data
);

	// entry status and operands
	logic [core_pkg::num_entries-1:0] busy;
	logic [core_pkg::num_entries-1:0] ready;
	logic [core_pkg::num_entries-1:0] grant;
	isa_pkg::alu_op_e ent_op [core_pkg::num_entries];
	isa_pkg::word_t   ent_v1 [core_pkg::num_entries];
	isa_pkg::word_t   ent_v2 [core_pkg::num_entries];

	// common data bus
	logic           cdb_valid;
	core_pkg::tag_t cdb_tag;
	isa_pkg::word_t cdb_value;

	rs_dispatch_if dsp_if ();

	////////////////////////////////////////
	// issue
	////////////////////////////////////////

	issue_unit i_issue_unit (
		.clock       (clock),
		.reset       (reset),
		.issue_valid (issue_valid),
		.issue_inst  (isa_pkg::inst_u'(issue_inst)),
		.issue_stall (issue_stall),
		.busy        (busy),
		.cdb_valid   (cdb_valid),
		.cdb_tag     (cdb_tag),
		.cdb_value   (cdb_value),
		.read_idx    (read_idx),
		.read_data   (read_data),
		.wb_valid    (wb_valid),
		.wb_rd       (wb_rd),
		.wb_data     (wb_data),
		.dsp         (dsp_if.source)
	);

	////////////////////////////////////////
	// reservation stations
	////////////////////////////////////////

	for (genvar g = 0; g < core_pkg::num_entries; g++) begin : g_entry
		rs_entry i_rs_entry (
			.clock     (clock),
			.reset     (reset),
			.index     (core_pkg::tag_t'(g)),
			.dsp       (dsp_if.sink),
			.cdb_valid (cdb_valid),
			.cdb_tag   (cdb_tag),
			.cdb_value (cdb_value),
			.grant     (grant[g]),
			.busy      (busy[g]),
			.ready     (ready[g]),
			.alu_op    (ent_op[g]),
			.value1    (ent_v1[g]),
			.value2    (ent_v2[g])
		);
	end

	// execute and broadcast
	alu_writeback i_alu_writeback (
		.clock     (clock),
		.reset     (reset),
		.ready     (ready),
		.alu_op    (ent_op),
		.value1    (ent_v1),
		.value2    (ent_v2),
		.grant     (grant),
		.cdb_valid (cdb_valid),
		.cdb_tag   (cdb_tag),
		.cdb_value (cdb_value)
	);

endmodule

/* bench/tomasulo_core_tb.sv */
// tomasulo_core_tb
// directed and random ALU programs against an in-order reference model;
// checks the final register state, every writeback, x0 and issue back-pressure
`timescale 1ns/10ps

module tomasulo_core_tb;

	// test lengths in issued words
	localparam int n_chain_dir  = 21;
	localparam int n_chain_rand = 60;
	localparam int n_x0         = 12;
	localparam int n_burst      = 40;
	localparam int n_waw_dir    = 6;
	localparam int n_waw_rand   = 40;
	localparam int n_total      = n_chain_dir + n_chain_rand + n_x0 + n_burst +
		n_waw_dir + n_waw_rand;
	localparam int cycle_limit  = 10 * n_total + 200;
	localparam int max_writes   = 256;

	logic              clock = 1'b0;
	logic              reset;
	logic              issue_valid;
	logic [31:0]       issue_inst;
	logic              issue_stall;
	isa_pkg::reg_idx_t read_idx;
	isa_pkg::word_t    read_data;
	logic              wb_valid;
	isa_pkg::reg_idx_t wb_rd;
	isa_pkg::word_t    wb_data;

	// reference model state and the history of values per register
	isa_pkg::word_t model_regs [isa_pkg::num_regs];
	isa_pkg::word_t produced [isa_pkg::num_regs][max_writes];
	int             produced_count [isa_pkg::num_regs];

	integer seed = 32'h9186e34a;
	string  test_name = "none";
	int     errors = 0;
	int     checks = 0;
	int     tests_run = 0;
	int     test_err_start = 0;
	int     stall_cycles = 0;
	int     cycle_count = 0;
	int     stall_before;

	tomasulo_core i_tomasulo_core (
		.clock       (clock),
		.reset       (reset),
		.issue_valid (issue_valid),
		.issue_inst  (issue_inst),
		.issue_stall (issue_stall),
		.read_idx    (read_idx),
		.read_data   (read_data),
		.wb_valid    (wb_valid),
		.wb_rd       (wb_rd),
		.wb_data     (wb_data)
	);

	always #10 clock = ~clock;

	// run limit from the total program length
	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout after %0d cycles in test %s, DUT did not drain", cycle_count,
				test_name);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
		input isa_pkg::reg_idx_t rd, input isa_pkg::reg_idx_t rs1,
		input isa_pkg::reg_idx_t rs2);
		isa_pkg::inst_u u;
		u.r.funct7 = f7;
		u.r.rs2    = rs2;
		u.r.rs1    = rs1;
		u.r.funct3 = f3;
		u.r.rd     = rd;
		u.r.opcode = 7'b0110011;
		return u;
	endfunction

	function automatic logic [31:0] i_word(input logic [2:0] f3, input isa_pkg::reg_idx_t rd,
		input isa_pkg::reg_idx_t rs1, input logic [11:0] imm);
		isa_pkg::inst_u u;
		u.i.imm    = imm;
		u.i.rs1    = rs1;
		u.i.funct3 = f3;
		u.i.rd     = rd;
		u.i.opcode = 7'b0010011;
		return u;
	endfunction

	// sel 0 to 8 picks ADD SUB AND OR XOR ADDI ANDI ORI XORI and others give SLL
	function automatic logic [31:0] kept_word(input int sel, input isa_pkg::reg_idx_t rd,
		input isa_pkg::reg_idx_t rs1, input isa_pkg::reg_idx_t rs2, input logic [11:0] imm);
		case (sel)
			0:       return r_word(7'h00, 3'b000, rd, rs1, rs2);
			1:       return r_word(7'h20, 3'b000, rd, rs1, rs2);
			2:       return r_word(7'h00, 3'b111, rd, rs1, rs2);
			3:       return r_word(7'h00, 3'b110, rd, rs1, rs2);
			4:       return r_word(7'h00, 3'b100, rd, rs1, rs2);
			5:       return i_word(3'b000, rd, rs1, imm);
			6:       return i_word(3'b111, rd, rs1, imm);
			7:       return i_word(3'b110, rd, rs1, imm);
			8:       return i_word(3'b100, rd, rs1, imm);
			default: return r_word(7'h00, 3'b001, rd, rs1, rs2);
		endcase
	endfunction

	// small register set so that dependences are frequent
	function automatic logic [31:0] random_word();
		int sel;
		isa_pkg::reg_idx_t rd;
		isa_pkg::reg_idx_t rs1;
		isa_pkg::reg_idx_t rs2;
		sel = rand_below(10);
		rd  = isa_pkg::reg_idx_t'(1 + rand_below(4));
		rs1 = isa_pkg::reg_idx_t'(rand_below(5));
		rs2 = isa_pkg::reg_idx_t'(rand_below(5));
		return kept_word(sel, rd, rs1, rs2, 12'($random(seed)));
	endfunction

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	// in-order execution straight from the RV32I rules
	task automatic model_apply(input logic [31:0] w);
		isa_pkg::inst_u u;
		isa_pkg::word_t a;
		isa_pkg::word_t b;
		isa_pkg::word_t res;
		logic kept;
		u    = w;
		a    = model_regs[u.r.rs1];
		b    = '0;
		res  = '0;
		kept = 1'b0;
		if (u.r.opcode == 7'b0110011) begin
			b    = model_regs[u.r.rs2];
			kept = 1'b1;
			case ({u.r.funct7, u.r.funct3})
				10'b0000000_000: res = a + b;
				10'b0100000_000: res = a - b;
				10'b0000000_111: res = a & b;
				10'b0000000_110: res = a | b;
				10'b0000000_100: res = a ^ b;
				default:         kept = 1'b0;
			endcase
		end else if (u.i.opcode == 7'b0010011) begin
			b    = {{20{u.i.imm[11]}}, u.i.imm};
			kept = 1'b1;
			case (u.i.funct3)
				3'b000:  res = a + b;
				3'b111:  res = a & b;
				3'b110:  res = a | b;
				3'b100:  res = a ^ b;
				default: kept = 1'b0;
			endcase
		end
		// x0 stays zero
		if (kept && u.r.rd != '0) begin
			model_regs[u.r.rd] = res;
			if (produced_count[u.r.rd] < max_writes) begin
				produced[u.r.rd][produced_count[u.r.rd]] = res;
				produced_count[u.r.rd] = produced_count[u.r.rd] + 1;
			end
		end
	endtask

	function automatic logic value_produced(input isa_pkg::reg_idx_t rd,
		input isa_pkg::word_t v);
		for (int k = 0; k < produced_count[rd]; k++) begin
			if (produced[rd][k] == v)
				return 1'b1;
		end
		return 1'b0;
	endfunction

	////////////////////////////////////////
	// drive, drain and check
	////////////////////////////////////////

	// starts just after a rising edge and returns at the accepting edge
	task automatic issue_word(input logic [31:0] w);
		logic taken;
		issue_valid <= 1'b1;
		issue_inst  <= w;
		taken = 1'b0;
		while (!taken) begin
			@(negedge clock);
			taken = !issue_stall;
			if (issue_stall)
				stall_cycles++;
			@(posedge clock);
		end
		model_apply(w);
	endtask

	task automatic random_program(input int count);
		for (int k = 0; k < count; k++)
			issue_word(random_word());
	endtask

	// stop issue and wait for an empty entry array and a quiet bus
	task automatic drain();
		issue_valid <= 1'b0;
		@(negedge clock);
		while (i_tomasulo_core.busy != '0 || i_tomasulo_core.cdb_valid)
			@(negedge clock);
		@(posedge clock);
	endtask

	task automatic check_regs();
		for (int r = 0; r < isa_pkg::num_regs; r++) begin
			read_idx <= isa_pkg::reg_idx_t'(r);
			@(negedge clock);
			checks++;
			assert (read_data == model_regs[r])
			else begin
				$display("Mismatch %s x%0d: expected %h, actual %h", test_name, r,
					model_regs[r], read_data);
				errors++;
			end
			@(posedge clock);
		end
	endtask

	task automatic start_test(input string name);
		test_name      = name;
		test_err_start = errors;
	endtask

	task automatic end_test();
		tests_run++;
		$display("test %s: %0d errors", test_name, errors - test_err_start);
	endtask

	// x0 is never reported as written
	assert property (@(posedge clock) disable iff (reset) wb_valid |-> wb_rd != '0)
		else begin
			$display("writeback to x0 reported on wb_valid in test %s", test_name);
			errors++;
		end

	// each writeback is a value the model produced for that register
	assert property (@(posedge clock) disable iff (reset)
		wb_valid |-> value_produced(wb_rd, wb_data))
		else begin
			$display("Mismatch %s wb x%0d: expected a model value such as %h, actual %h",
				test_name, wb_rd, model_regs[wb_rd], wb_data);
			errors++;
		end

	always @(posedge clock) begin
		if (!reset && wb_valid)
			checks++;
	end

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial begin
		reset       = 1'b1;
		issue_valid = 1'b0;
		issue_inst  = '0;
		read_idx    = '0;
		for (int r = 0; r < isa_pkg::num_regs; r++) begin
			model_regs[r]     = '0;
			produced_count[r] = 0;
		end
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);

		// quiet outputs and zeroed registers
		start_test("reset");
		@(negedge clock);
		checks += 2;
		assert (!wb_valid)
		else begin
			$display("wb_valid is high right after reset");
			errors++;
		end
		assert (!issue_stall)
		else begin
			$display("issue_stall is high right after reset");
			errors++;
		end
		@(posedge clock);
		check_regs();
		end_test();

		// seed values then a rotating chain through all nine operations
		start_test("chain");
		issue_word(i_word(3'b000, 5'd1, 5'd0, 12'h123));
		issue_word(i_word(3'b000, 5'd2, 5'd0, 12'hffb));
		issue_word(i_word(3'b000, 5'd3, 5'd1, 12'h7f0));
		for (int i = 0; i < 18; i++)
			issue_word(kept_word(i % 9, isa_pkg::reg_idx_t'(1 + i % 4),
				isa_pkg::reg_idx_t'(1 + (i + 3) % 4), isa_pkg::reg_idx_t'(1 + (i + 2) % 4),
				12'(i * 37 + 1)));
		random_program(n_chain_rand);
		drain();
		check_regs();
		end_test();

		// even words target x0 and odd words read it
		start_test("x0");
		for (int i = 0; i < n_x0; i++) begin
			if (i % 2 == 0)
				issue_word(kept_word(i % 9, 5'd0, isa_pkg::reg_idx_t'(1 + i % 4), 5'd2,
					12'(i * 91 + 5)));
			else
				issue_word(kept_word(i % 9, isa_pkg::reg_idx_t'(1 + i % 4), 5'd0, 5'd0,
					12'(i * 13)));
		end
		drain();
		check_regs();
		end_test();

		// serial chain on x1 drains at half the issue rate
		start_test("burst");
		stall_before = stall_cycles;
		for (int i = 0; i < n_burst; i++)
			issue_word(kept_word(i % 9, 5'd1, 5'd1, 5'd2, 12'(i * 29 + 3)));
		drain();
		checks++;
		assert (stall_cycles > stall_before)
		else begin
			$display("issue_stall never went high during the dependent burst");
			errors++;
		end
		check_regs();
		end_test();

		// slow x4 write overtaken by a later fast one
		start_test("waw");
		issue_word(r_word(7'h00, 3'b000, 5'd3, 5'd3, 5'd1));
		issue_word(r_word(7'h00, 3'b000, 5'd3, 5'd3, 5'd3));
		issue_word(r_word(7'h00, 3'b000, 5'd4, 5'd3, 5'd3));
		issue_word(i_word(3'b000, 5'd4, 5'd0, 12'h007));
		issue_word(r_word(7'h00, 3'b100, 5'd2, 5'd4, 5'd1));
		issue_word(i_word(3'b000, 5'd4, 5'd0, 12'h3c5));
		// x4 holds the last directed value before random traffic
		drain();
		check_regs();
		random_program(n_waw_rand);
		drain();
		check_regs();
		end_test();

		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* filelist.f */
verilog/isa_pkg.sv
verilog/core_pkg.sv
verilog/rs_dispatch_if.sv
verilog/issue_unit.sv
verilog/rs_entry.sv
verilog/alu_writeback.sv
verilog/tomasulo_core.sv
bench/tomasulo_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it and search the log for the result
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module tomasulo_core_tb -f filelist.f -o sim_tomasulo
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_tomasulo > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^ALL CHECKS PASSED$" "$log"; then
	exit 0
fi
echo "pass message not found in $log"
exit 1
